// ==== list.f ====
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_exec_fsm.sv
rtl/id_stage.sv
sim/id_stage_properties.sv
sim/tb_id_stage.sv

// ==== rtl/id_decoder.sv ====
/*
  Combinational RV32I subset decoder. Any encoding outside OP, OP-IMM,
  LUI, AUIPC, LOAD, STORE, BRANCH, JAL and JALR is flagged illegal and
  all of its enables are forced low. Writes to x0 are not filtered.
*/
`timescale 1ns/10ps

module id_decoder import id_pkg::*; (
  input  logic [XLEN-1:0]       instr_rdata_i,
  output logic                  illegal_insn_o,
  output alu_op_e               alu_operator_o,
  output op_a_sel_e             op_a_sel_o,
  output op_b_sel_e             op_b_sel_o,
  output imm_b_sel_e            imm_b_sel_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_ren_a_o,
  output logic                  rf_ren_b_o,
  output logic                  rf_we_o,
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  output logic                  branch_o,
  output logic                  jump_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Register fields sit at fixed positions in every format
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  // Arithmetic op shared by OP and OP-IMM, alt selects sub or sra
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    illegal_insn_o = 1'b0;
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;
    rf_ren_a_o     = 1'b0;
    rf_ren_b_o     = 1'b0;
    rf_we_o        = 1'b0;
    lsu_req_o      = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_type_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;
    branch_o       = 1'b0;
    jump_o         = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        rf_ren_a_o     = 1'b1;
        rf_ren_b_o     = 1'b1;
        rf_we_o        = 1'b1;
        op_b_sel_o     = OP_B_REG_B;
        alu_operator_o = arith_op(funct3, funct7[5]);
        // Only sub and sra use the alternate funct7
        illegal_insn_o = !(funct7 == 7'h00 ||
                           (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OPCODE_OP_IMM: begin
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        alu_operator_o = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
        // Shift immediates carry a funct7 of their own
        if (funct3 == 3'b001) begin
          illegal_insn_o = funct7 != 7'h00;
        end else if (funct3 == 3'b101) begin
          illegal_insn_o = funct7 != 7'h00 && funct7 != 7'h20;
        end
      end
      OPCODE_LUI: begin
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_ZERO;
        imm_b_sel_o = IMM_B_U;
      end
      OPCODE_AUIPC: begin
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
      end
      OPCODE_LOAD: begin
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        lsu_req_o      = 1'b1;
        lsu_sign_ext_o = ~funct3[2];
        // funct3 low bits give the size, bit 2 marks unsigned
        case (funct3[1:0])
          2'b00:   lsu_type_o = LSU_BYTE;
          2'b01:   lsu_type_o = LSU_HALF;
          default: lsu_type_o = LSU_WORD;
        endcase
        illegal_insn_o = funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111;
      end
      OPCODE_STORE: begin
        rf_ren_a_o  = 1'b1;
        rf_ren_b_o  = 1'b1;
        lsu_req_o   = 1'b1;
        lsu_we_o    = 1'b1;
        imm_b_sel_o = IMM_B_S;
        case (funct3)
          3'b000:  lsu_type_o = LSU_BYTE;
          3'b001:  lsu_type_o = LSU_HALF;
          3'b010:  lsu_type_o = LSU_WORD;
          default: illegal_insn_o = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        // Comparison of rs1 and rs2 in the first cycle
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        branch_o   = 1'b1;
        op_b_sel_o = OP_B_REG_B;
        case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_insn_o = 1'b1;
        endcase
      end
      OPCODE_JAL, OPCODE_JALR: begin
        // Link value pc + 4 goes through the ALU
        rf_ren_a_o     = opcode == OPCODE_JALR;
        rf_we_o        = 1'b1;
        jump_o         = 1'b1;
        op_a_sel_o     = OP_A_CURRPC;
        imm_b_sel_o    = IMM_B_INCR_PC;
        illegal_insn_o = opcode == OPCODE_JALR && funct3 != 3'b000;
      end
      default: illegal_insn_o = 1'b1;
    endcase

    // No side effects from an illegal encoding
    if (illegal_insn_o) begin
      rf_ren_a_o = 1'b0;
      rf_ren_b_o = 1'b0;
      rf_we_o    = 1'b0;
      lsu_req_o  = 1'b0;
      lsu_we_o   = 1'b0;
      branch_o   = 1'b0;
      jump_o     = 1'b0;
    end
  end

endmodule

// ==== rtl/id_exec_fsm.sv ====
/*
  First-cycle / multi-cycle execute control without a writeback stage.
  The stage runs only while fetch_enable_i is high. At most one PC set
  is issued per instruction; the register write fires in the done cycle.
*/
`timescale 1ns/10ps

module id_exec_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic fetch_enable_i,
  input  logic illegal_insn_i,
  input  logic rf_we_dec_i,
  input  logic lsu_req_dec_i,
  input  logic branch_i,
  input  logic jump_i,
  input  logic branch_decision_i,
  input  logic ex_valid_i,
  input  logic lsu_resp_valid_i,
  output logic illegal_insn_o,
  output logic lsu_req_o,
  output logic rf_we_o,
  output logic pc_set_o,
  output logic instr_done_o,
  output logic id_in_ready_o,
  output logic instr_first_cycle_o
);

  typedef enum logic { FIRST_CYCLE, MULTI_CYCLE } id_fsm_e;

  id_fsm_e id_fsm_q, id_fsm_d;
  logic    instr_executing;
  logic    instr_first_cycle;
  logic    multicycle_done;
  logic    stall_mem, stall_branch, stall_jump, stall_id;
  logic    branch_set_d, branch_set_q;
  logic    jump_set;
  logic    set_done_d, set_done_q;

  // Valid instruction and a running core
  assign instr_executing   = instr_valid_i & fetch_enable_i;
  assign instr_first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);
  assign multicycle_done   = lsu_req_dec_i ? lsu_resp_valid_i : ex_valid_i;

  // Load/store always waits past its first cycle for the response
  assign stall_mem = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | instr_first_cycle);

  ///////////////////////////////////////////////////////////////////////
  // ID-EX state machine
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;

    if (instr_executing) begin
      case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_req_dec_i) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_i) begin
            // Taken branch sets the PC next cycle, not-taken retires now
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_i) begin
            id_fsm_d   = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
          end
        end
        default: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = branch_i;
            stall_jump   = jump_i;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_executing) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // PC set tracking
  ///////////////////////////////////////////////////////////////////////

  // Flag stays set from the first PC set until the instruction retires
  assign set_done_d = (branch_set_q | jump_set | set_done_q) & ~instr_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

  assign pc_set_o = (branch_set_q | jump_set) & ~set_done_q;

  ///////////////////////////////////////////////////////////////////////
  // Stall, completion and side-effect gating
  ///////////////////////////////////////////////////////////////////////

  assign stall_id      = stall_mem | stall_branch | stall_jump;
  assign instr_done_o  = instr_executing & ~stall_id;
  assign id_in_ready_o = ~instr_valid_i | instr_done_o;

  // Request only once, in the first cycle of the access
  assign lsu_req_o = instr_executing & instr_first_cycle & lsu_req_dec_i;

  // Write in the retire cycle, so loads wait for their response data
  assign rf_we_o = rf_we_dec_i & ~illegal_insn_i & instr_done_o;

  assign illegal_insn_o      = instr_valid_i & illegal_insn_i;
  assign instr_first_cycle_o = instr_first_cycle;

endmodule

// ==== rtl/id_operand_mux.sv ====
/*
  Immediate construction and ALU operand selection. No forwarding:
  register operands come straight from the register file read ports.
*/
`timescale 1ns/10ps

module id_operand_mux import id_pkg::*; (
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic [XLEN-1:0] pc_id_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  input  logic            lsu_addr_incr_req_i,
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  imm_b_sel_e      imm_b_sel_i,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o
);

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm_b;
  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;

  ///////////////////////////////////////////////////////////////////////
  // Immediates
  ///////////////////////////////////////////////////////////////////////

  // All sign bits come from instruction bit 31
  assign imm_i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b_type = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                       instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_type = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                       instr_rdata_i[30:21], 1'b0};

  // Second half of a misaligned access computes last address + 4
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : op_a_sel_i;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : op_b_sel_i;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

  ///////////////////////////////////////////////////////////////////////
  // Operand muxes
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    case (imm_b_sel)
      IMM_B_I: imm_b = imm_i_type;
      IMM_B_S: imm_b = imm_s_type;
      IMM_B_B: imm_b = imm_b_type;
      IMM_B_U: imm_b = imm_u_type;
      IMM_B_J: imm_b = imm_j_type;
      // Both increments are one word
      default: imm_b = PC_INCR;
    endcase
  end

  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

// ==== rtl/id_pkg.sv ====
/*
  Shared encodings for the RV32I decode and execute-control stage.
  Only the kept instruction classes have opcodes here. Compressed,
  CSR and M-extension encodings are not represented.
*/
package id_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Widths and constants
  ///////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // PC step and second-half address step of a misaligned access
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  ///////////////////////////////////////////////////////////////////////
  // Encodings
  ///////////////////////////////////////////////////////////////////////

  // Major opcodes of the decoded classes
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU operations, comparisons last for branches
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_FWD,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate for operand B
  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  // Access size toward the LSU
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

endpackage

// ==== rtl/id_stage.sv ====
/*
  Decode and execute-control stage of a small in-order RV32I core.
  No writeback stage and no forwarding: result and rs2 data pass
  straight through. Read addresses are zeroed for unused ports.
*/
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  // IF-ID register
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic [XLEN-1:0]       pc_id_i,
  // Register file read data and EX result
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  input  logic [XLEN-1:0]       result_ex_i,
  input  logic                  branch_decision_i,
  input  logic                  ex_valid_i,
  // LSU status
  input  logic                  lsu_resp_valid_i,
  input  logic                  lsu_addr_incr_req_i,
  input  logic [XLEN-1:0]       lsu_addr_last_i,
  output logic                  illegal_insn_o,
  output logic                  id_in_ready_o,
  output logic                  instr_done_o,
  output logic                  pc_set_o,
  output alu_op_e               alu_operator_o,
  output logic [XLEN-1:0]       alu_operand_a_o,
  output logic [XLEN-1:0]       alu_operand_b_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_we_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  output logic [XLEN-1:0]       lsu_wdata_o
);

  logic                  illegal_insn_dec;
  op_a_sel_e             op_a_sel;
  op_b_sel_e             op_b_sel;
  imm_b_sel_e            imm_b_sel;
  logic [REG_ADDR_W-1:0] raddr_a_dec, raddr_b_dec;
  logic                  rf_ren_a, rf_ren_b;
  logic                  rf_we_dec, lsu_req_dec;
  logic                  branch_dec, jump_dec;
  // Observed by the bound handshake checks
  logic                  instr_first_cycle;

  id_decoder decoder_inst (
    .instr_rdata_i (instr_rdata_i),
    .illegal_insn_o(illegal_insn_dec),
    .alu_operator_o(alu_operator_o),
    .op_a_sel_o    (op_a_sel),
    .op_b_sel_o    (op_b_sel),
    .imm_b_sel_o   (imm_b_sel),
    .rf_raddr_a_o  (raddr_a_dec),
    .rf_raddr_b_o  (raddr_b_dec),
    .rf_waddr_o    (rf_waddr_o),
    .rf_ren_a_o    (rf_ren_a),
    .rf_ren_b_o    (rf_ren_b),
    .rf_we_o       (rf_we_dec),
    .lsu_req_o     (lsu_req_dec),
    .lsu_we_o      (lsu_we_o),
    .lsu_type_o    (lsu_type_o),
    .lsu_sign_ext_o(lsu_sign_ext_o),
    .branch_o      (branch_dec),
    .jump_o        (jump_dec)
  );

  id_operand_mux operand_mux_inst (
    .instr_rdata_i      (instr_rdata_i),
    .pc_id_i            (pc_id_i),
    .rf_rdata_a_i       (rf_rdata_a_i),
    .rf_rdata_b_i       (rf_rdata_b_i),
    .lsu_addr_last_i    (lsu_addr_last_i),
    .lsu_addr_incr_req_i(lsu_addr_incr_req_i),
    .op_a_sel_i         (op_a_sel),
    .op_b_sel_i         (op_b_sel),
    .imm_b_sel_i        (imm_b_sel),
    .alu_operand_a_o    (alu_operand_a_o),
    .alu_operand_b_o    (alu_operand_b_o)
  );

  id_exec_fsm exec_fsm_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .fetch_enable_i     (fetch_enable_i),
    .illegal_insn_i     (illegal_insn_dec),
    .rf_we_dec_i        (rf_we_dec),
    .lsu_req_dec_i      (lsu_req_dec),
    .branch_i           (branch_dec),
    .jump_i             (jump_dec),
    .branch_decision_i  (branch_decision_i),
    .ex_valid_i         (ex_valid_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .illegal_insn_o     (illegal_insn_o),
    .lsu_req_o          (lsu_req_o),
    .rf_we_o            (rf_we_o),
    .pc_set_o           (pc_set_o),
    .instr_done_o       (instr_done_o),
    .id_in_ready_o      (id_in_ready_o),
    .instr_first_cycle_o(instr_first_cycle)
  );

  // Unused read ports see x0
  assign rf_raddr_a_o = rf_ren_a ? raddr_a_dec : '0;
  assign rf_raddr_b_o = rf_ren_b ? raddr_b_dec : '0;

  assign rf_wdata_o  = result_ex_i;
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --assert --timescale 1ns/10ps -f list.f \
  --top-module tb_id_stage -o tb_id_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_id_stage +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/id_stage_properties.sv ====
/*
  Handshake rules of id_stage, bound into every instance of the stage.
  Checks are off while rst_ni is low. Failures are counted as well.
*/
`timescale 1ns/10ps

module id_stage_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic fetch_enable_i,
  input logic instr_valid_i,
  input logic instr_first_cycle_i,
  input logic illegal_insn_i,
  input logic instr_done_i,
  input logic pc_set_i,
  input logic rf_we_i,
  input logic lsu_req_i
);

  int fail_count = 0;

  // Request only in the first cycle of a load or store, and never twice
  a_lsu_req_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> instr_valid_i && instr_first_cycle_i && !instr_done_i ##1 !lsu_req_i)
  else begin
    fail_count++;
    $error("lsu_req_o outside the first cycle or held for two cycles");
  end

  // A second PC set before retire would redirect fetch twice
  a_pc_set_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i && !instr_done_i |=> !pc_set_i)
  else begin
    fail_count++;
    $error("pc_set_o asserted twice for one instruction");
  end

  // Stopped core retires nothing and has no side effects
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_enable_i |-> !instr_done_i && !rf_we_i && !lsu_req_i && !pc_set_i)
  else begin
    fail_count++;
    $error("control output active while fetch is disabled");
  end

  // Illegal retires at once and is otherwise silent
  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i && fetch_enable_i |-> instr_done_i && !rf_we_i && !lsu_req_i && !pc_set_i)
  else begin
    fail_count++;
    $error("illegal instruction caused a side effect or did not retire");
  end

endmodule

bind id_stage id_stage_properties props_inst (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .fetch_enable_i     (fetch_enable_i),
  .instr_valid_i      (instr_valid_i),
  .instr_first_cycle_i(instr_first_cycle),
  .illegal_insn_i     (illegal_insn_o),
  .instr_done_i       (instr_done_o),
  .pc_set_i           (pc_set_o),
  .rf_we_i            (rf_we_o),
  .lsu_req_i          (lsu_req_o)
);

// ==== sim/tb_id_stage.sv ====
/*
  Testbench for id_stage. One instruction at a time with a bubble after
  each, EX and LSU answers after 1 to 4 cycles. fetch_enable_i drops only
  before the first instruction, never while one is in flight.
*/
`timescale 1ns/10ps

module tb_id_stage import id_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 6;
  localparam int NUM_INSTR    = 90;

  // Instruction classes by completion timing
  typedef enum int { K_ALU, K_MEM, K_TAKEN, K_NOT_TAKEN, K_JUMP, K_ILLEGAL } kind_e;

  logic                  clk_i, rst_ni, fetch_enable_i, instr_valid_i;
  logic [XLEN-1:0]       instr_rdata_i, pc_id_i, rf_rdata_a_i, rf_rdata_b_i;
  logic [XLEN-1:0]       result_ex_i, lsu_addr_last_i;
  logic                  branch_decision_i, ex_valid_i, lsu_resp_valid_i, lsu_addr_incr_req_i;
  logic                  illegal_insn_o, id_in_ready_o, instr_done_o, pc_set_o;
  alu_op_e               alu_operator_o;
  logic [XLEN-1:0]       alu_operand_a_o, alu_operand_b_o, rf_wdata_o, lsu_wdata_o;
  logic [REG_ADDR_W-1:0] rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
  logic                  rf_we_o, lsu_req_o, lsu_we_o, lsu_sign_ext_o;
  lsu_type_e             lsu_type_o;
  integer                seed;
  int                    error_count;

  // Decode expected for the instruction under test
  alu_op_e               exp_op;
  logic [REG_ADDR_W-1:0] exp_raddr_a, exp_raddr_b, exp_waddr;
  lsu_type_e             exp_lsu_type;
  logic                  exp_sign_ext;

  id_stage id_stage_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Worst case per instruction is 5 cycles plus the bubble
  initial begin
    #((NUM_INSTR * 8 + RESET_CYCLES + IDLE_CYCLES + 4) * CLK_PERIOD);
    $display("Timeout: the instruction sequence did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  task automatic expect_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
    assert (got === exp) else begin
      error_count++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_bit(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      error_count++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Decoder outputs in the first cycle, unused read ports see x0
  task automatic expect_decode(input kind_e kind, input logic writes);
    if (kind != K_ILLEGAL) begin
      expect_word(32'(alu_operator_o), 32'(exp_op), "alu_operator_o");
    end
    expect_word(32'(rf_raddr_a_o), 32'(exp_raddr_a), "rf_raddr_a_o");
    expect_word(32'(rf_raddr_b_o), 32'(exp_raddr_b), "rf_raddr_b_o");
    if (writes) begin
      expect_word(32'(rf_waddr_o), 32'(exp_waddr), "rf_waddr_o");
    end
    if (kind == K_MEM) begin
      expect_word(32'(lsu_type_o), 32'(exp_lsu_type), "lsu_type_o");
    end
    if (kind == K_MEM && writes) begin
      expect_bit(lsu_sign_ext_o, exp_sign_ext, "lsu_sign_ext_o");
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Instruction formats
  ///////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
  endfunction

  // Offset bit 0 is implied zero
  function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // One instruction from valid to retire, then a bubble
  ///////////////////////////////////////////////////////////////////////

  task automatic run_instr(input logic [31:0] instr, input kind_e kind,
      input logic [XLEN-1:0] exp_a, input logic [XLEN-1:0] exp_b, input logic writes);
    int   delay;
    int   done_cycle;
    int   cycle;
    int   pc_sets;
    logic finished;
    delay      = 1 + ($random(seed) & 3);
    done_cycle = (kind inside {K_MEM, K_TAKEN, K_JUMP}) ? delay : 0;
    cycle      = 0;
    pc_sets    = 0;
    finished   = 1'b0;
    instr_valid_i     = 1'b1;
    instr_rdata_i     = instr;
    branch_decision_i = kind == K_TAKEN;
    while (!finished) begin
      // EX and LSU model answers once the delay is over
      ex_valid_i          = cycle == delay && (kind == K_TAKEN || kind == K_JUMP);
      lsu_resp_valid_i    = cycle == delay && kind == K_MEM;
      // Misaligned second half right after the request
      lsu_addr_incr_req_i = kind == K_MEM && cycle == 1 && delay > 1;
      #10;
      if (lsu_addr_incr_req_i) begin
        expect_word(alu_operand_a_o, lsu_addr_last_i, "operand A on address increment");
        expect_word(alu_operand_b_o, PC_INCR, "operand B on address increment");
      end else if (cycle == 0 && kind != K_ILLEGAL) begin
        expect_word(alu_operand_a_o, exp_a, "operand A");
        expect_word(alu_operand_b_o, exp_b, "operand B");
      end
      if (cycle == 0) begin
        expect_decode(kind, writes);
      end
      if (kind == K_MEM && cycle == 0) begin
        expect_bit(lsu_we_o, !writes, "lsu_we_o");
      end
      expect_word(rf_wdata_o, result_ex_i, "rf_wdata_o");
      expect_word(lsu_wdata_o, rf_rdata_b_i, "lsu_wdata_o");
      expect_bit(instr_done_o, cycle == done_cycle, "instr_done_o");
      expect_bit(id_in_ready_o, cycle == done_cycle, "id_in_ready_o");
      expect_bit(illegal_insn_o, kind == K_ILLEGAL, "illegal_insn_o");
      expect_bit(lsu_req_o, kind == K_MEM && cycle == 0, "lsu_req_o");
      expect_bit(rf_we_o, writes && cycle == done_cycle, "rf_we_o");
      // Jump sets the PC at once, a taken branch one cycle later
      expect_bit(pc_set_o, (kind == K_JUMP && cycle == 0) || (kind == K_TAKEN && cycle == 1),
                 "pc_set_o");
      if (pc_set_o) begin
        pc_sets++;
      end
      finished = instr_done_o;
      @(negedge clk_i);
      cycle++;
    end
    expect_word(pc_sets, (kind == K_JUMP || kind == K_TAKEN) ? 32'd1 : 32'd0, "PC set count");
    instr_valid_i       = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_resp_valid_i    = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    #10;
    expect_bit(pc_set_o, 1'b0, "pc_set_o in bubble");
    expect_bit(instr_done_o, 1'b0, "instr_done_o in bubble");
    expect_bit(id_in_ready_o, 1'b1, "id_in_ready_o in bubble");
    @(negedge clk_i);
  endtask

  initial begin
    logic [4:0]      rd, rs1, rs2;
    logic [11:0]     imm12;
    logic [19:0]     imm20;
    logic [XLEN-1:0] sext;
    logic            pick;
    int              i;
    seed                = 37607;
    error_count         = 0;
    rst_ni              = 1'b0;
    fetch_enable_i      = 1'b0;
    instr_valid_i       = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    rf_rdata_a_i        = '0;
    rf_rdata_b_i        = '0;
    result_ex_i         = '0;
    lsu_addr_last_i     = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_resp_valid_i    = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    // A valid ADDI must not retire while fetch is disabled
    instr_valid_i = 1'b1;
    instr_rdata_i = i_format(12'h001, 5'd1, 3'b000, 5'd2, OPCODE_OP_IMM);
    repeat (IDLE_CYCLES) begin
      #10;
      expect_bit(instr_done_o, 1'b0, "instr_done_o with fetch disabled");
      expect_bit(rf_we_o, 1'b0, "rf_we_o with fetch disabled");
      @(negedge clk_i);
    end
    instr_valid_i  = 1'b0;
    fetch_enable_i = 1'b1;
    @(negedge clk_i);

    for (i = 0; i < NUM_INSTR; i++) begin
      rd              = 5'($random(seed));
      rs1             = 5'($random(seed));
      rs2             = 5'($random(seed));
      imm12           = 12'($random(seed));
      imm20           = 20'($random(seed));
      pick            = 1'($random(seed));
      sext            = {{20{imm12[11]}}, imm12};
      rf_rdata_a_i    = $random(seed);
      rf_rdata_b_i    = $random(seed);
      result_ex_i     = $random(seed);
      lsu_addr_last_i = $random(seed);
      pc_id_i         = $random(seed) & 32'hffff_fffc;
      // Most classes add, read rs1 only and write rd
      exp_op      = ALU_ADD;
      exp_raddr_a = rs1;
      exp_raddr_b = '0;
      exp_waddr   = rd;
      case (i % 9)
        0: run_instr(i_format(imm12, rs1, 3'b000, rd, OPCODE_OP_IMM), K_ALU,
                     rf_rdata_a_i, sext, 1'b1);
        1: begin
          exp_raddr_b = rs2;
          run_instr(r_format(7'h00, rs2, rs1, 3'b000, rd, OPCODE_OP), K_ALU,
                    rf_rdata_a_i, rf_rdata_b_i, 1'b1);
        end
        2: begin
          exp_raddr_a = '0;
          run_instr({imm20, rd, OPCODE_LUI}, K_ALU, '0, {imm20, 12'h000}, 1'b1);
        end
        3: begin
          exp_raddr_a = '0;
          run_instr({imm20, rd, OPCODE_AUIPC}, K_ALU, pc_id_i, {imm20, 12'h000}, 1'b1);
        end
        4: begin
          // LW is a signed word, LBU an unsigned byte
          exp_lsu_type = pick ? LSU_WORD : LSU_BYTE;
          exp_sign_ext = pick;
          run_instr(i_format(imm12, rs1, pick ? 3'b010 : 3'b100, rd, OPCODE_LOAD), K_MEM,
                    rf_rdata_a_i, sext, 1'b1);
        end
        5: begin
          exp_raddr_b  = rs2;
          exp_lsu_type = pick ? LSU_WORD : LSU_HALF;
          run_instr(s_format(imm12, rs2, rs1, pick ? 3'b010 : 3'b001), K_MEM,
                    rf_rdata_a_i, sext, 1'b0);
        end
        6: begin
          exp_op      = ALU_EQ;
          exp_raddr_b = rs2;
          run_instr(b_format({imm12, 1'b0}, rs2, rs1, 3'b000), pick ? K_TAKEN : K_NOT_TAKEN,
                    rf_rdata_a_i, rf_rdata_b_i, 1'b0);
        end
        7: begin
          // JAL has no rs1, JALR reads it
          exp_raddr_a = pick ? 5'd0 : rs1;
          run_instr(pick ? j_format({imm20, 1'b0}, rd)
                         : i_format(imm12, rs1, 3'b000, rd, OPCODE_JALR),
                    K_JUMP, pc_id_i, PC_INCR, 1'b1);
        end
        // Custom-0 opcode or an M-extension multiply
        default: begin
          exp_raddr_a = '0;
          run_instr(r_format(pick ? 7'h01 : 7'h00, rs2, rs1, 3'b000, rd,
                             pick ? 7'h33 : 7'h0b), K_ILLEGAL, '0, '0, 1'b0);
        end
      endcase
    end

    $display("Checks done: %0d value errors, %0d handshake assertion failures",
             error_count, id_stage_inst.props_inst.fail_count);
    if (error_count == 0 && id_stage_inst.props_inst.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
